/* design/ramio_config.svh */
// ramio configuration
// widths, I/O addresses, cache size and UART bit time for the bridge
`ifndef RAMIO_CONFIG_SVH
`define RAMIO_CONFIG_SVH

// client side widths
`define RAMIO_ADDR_W 32
`define RAMIO_DATA_W 32

// burst ram depth, counted in 64-bit double words
`define RAMIO_RAM_ADDR_W 10

// 2 ^ value lines of 32 bytes each
`define RAMIO_LINE_IDX_W 1

// memory mapped I/O, top of the address space
`define RAMIO_ADDR_LED      32'hFFFF_FFFE
`define RAMIO_ADDR_UART_OUT 32'hFFFF_FFFC
`define RAMIO_ADDR_UART_IN  32'hFFFF_FFFA

// uart bit time in clocks, short for simulation
`define RAMIO_CLKS_PER_BIT 8

`endif

/* design/ramio_pkg.sv */
// ramio package
// types shared by the bridge and the cache
package ramio_pkg;

  // one 32-bit word seen as bytes or as half words
  // lane 0 is the least significant one
  typedef union packed {
    logic [3:0][7:0]  b;
    logic [1:0][15:0] h;
  } lane_word_t;

endpackage

/* design/cache_bus_if.sv */
// cache bus
// one word access from the bridge to the cache, held until data_out_ready
`timescale 1ns/1ps

interface cache_bus_if #(
  parameter int addr_w = 32,
  parameter int data_w = 32
);

  // request, held stable by the client until data_out_ready
  logic              enable;
  logic [addr_w-1:0] address;
  logic [data_w-1:0] data_in;
  // byte enables, zero means read
  logic [3:0]        write_enable;

  // response
  logic [data_w-1:0] data_out;
  logic              data_out_ready;
  logic              busy;

  modport client (
    output enable, address, data_in, write_enable,
    input  data_out, data_out_ready, busy
  );

  modport cache (
    input  enable, address, data_in, write_enable,
    output data_out, data_out_ready, busy
  );

endinterface

/* design/uart_tx.sv */
// uart transmitter
// 8 data bits, no parity, one stop bit; go starts a frame, bsy covers it
`timescale 1ns/1ps
`include "ramio_config.svh"

module uart_tx #(
  parameter int clks_per_bit = `RAMIO_CLKS_PER_BIT
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] data,
  input  logic       go,
  output logic       tx,
  output logic       bsy
);

  localparam int cnt_w = $clog2(clks_per_bit + 1);

  typedef enum logic [1:0] {s_idle, s_send, s_wait} state_t;

  state_t           state;
  logic [cnt_w-1:0] clk_cnt;
  logic [3:0]       bit_cnt;
  // stop bit above the data bits, shifted out lsb first
  logic [8:0]       shreg;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= s_idle;
      tx      <= 1'b1;
      bsy     <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
      shreg   <= '1;
    end else begin
      unique case (state)
        s_idle: if (go) begin
          // start bit goes out in the next cycle
          shreg   <= {1'b1, data};
          tx      <= 1'b0;
          bsy     <= 1'b1;
          clk_cnt <= '0;
          bit_cnt <= '0;
          state   <= s_send;
        end
        s_send: if (clk_cnt == cnt_w'(clks_per_bit - 1)) begin
          clk_cnt <= '0;
          if (bit_cnt == 4'd9) begin
            // stop bit done
            bsy   <= 1'b0;
            tx    <= 1'b1;
            state <= s_wait;
          end else begin
            tx      <= shreg[0];
            shreg   <= {1'b1, shreg[8:1]};
            bit_cnt <= bit_cnt + 4'd1;
          end
        end else begin
          clk_cnt <= clk_cnt + cnt_w'(1);
        end
        // sender must drop go before the next frame
        s_wait: if (!go) state <= s_idle;
        default: state <= s_idle;
      endcase
    end
  end

endmodule

/* design/uart_rx.sv */
// uart receiver
// 8 data bits, one stop bit, each bit sampled in the middle of its bit time
// data_ready holds the byte until go drops
`timescale 1ns/1ps
`include "ramio_config.svh"

module uart_rx #(
  parameter int clks_per_bit = `RAMIO_CLKS_PER_BIT
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       go,
  output logic [7:0] data,
  output logic       data_ready
);

  localparam int cnt_w = $clog2(clks_per_bit + 1);

  typedef enum logic [2:0] {s_idle, s_start, s_data, s_stop, s_ready} state_t;

  state_t           state;
  logic [cnt_w-1:0] clk_cnt;
  logic [2:0]       bit_cnt;
  // two flop synchronizer, line idles high
  logic             rx_meta;
  logic             rx_s;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta    <= 1'b1;
      rx_s       <= 1'b1;
      state      <= s_idle;
      clk_cnt    <= '0;
      bit_cnt    <= '0;
      data_ready <= 1'b0;
    end else begin
      rx_meta <= rx;
      rx_s    <= rx_meta;
      clk_cnt <= clk_cnt + cnt_w'(1);
      unique case (state)
        s_idle: begin
          clk_cnt <= '0;
          if (go && !rx_s) state <= s_start;
        end
        // half a bit in, the start bit must still be low
        s_start: if (clk_cnt == cnt_w'(clks_per_bit / 2 - 1)) begin
          clk_cnt <= '0;
          bit_cnt <= '0;
          state   <= rx_s ? s_idle : s_data;
        end
        s_data: if (clk_cnt == cnt_w'(clks_per_bit - 1)) begin
          clk_cnt <= '0;
          data    <= {rx_s, data[7:1]};
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) state <= s_stop;
        end
        s_stop: if (clk_cnt == cnt_w'(clks_per_bit - 1)) begin
          // a low stop bit drops the frame
          data_ready <= rx_s;
          state      <= rx_s ? s_ready : s_idle;
        end
        s_ready: if (!go) begin
          data_ready <= 1'b0;
          state      <= s_idle;
        end
        default: state <= s_idle;
      endcase
    end
  end

endmodule

/* design/cache.sv */
// direct mapped write-through cache, 32-byte lines, write allocate
// misses fill a whole line with a 4-beat read burst
// every write merges into the line and writes the line back as a 4-beat burst
`timescale 1ns/1ps
`include "ramio_config.svh"

module cache (
  input  logic                         clk,
  input  logic                         rst_n,
  cache_bus_if.cache                   bus,
  output logic                         br_cmd,
  output logic                         br_cmd_en,
  output logic [`RAMIO_RAM_ADDR_W-1:0] br_addr,
  output logic [63:0]                  br_wr_data,
  input  logic [63:0]                  br_rd_data,
  input  logic                         br_rd_data_valid
);

  localparam int idx_w = `RAMIO_LINE_IDX_W;
  localparam int lines = 1 << idx_w;
  // byte address bits above offset and index that still reach the ram
  localparam int tag_w = `RAMIO_RAM_ADDR_W + 3 - 5 - idx_w;

  typedef enum logic [2:0] {s_idle, s_lookup, s_fill, s_merge, s_write, s_done} state_t;

  state_t             state;
  // fill and write burst beat counter
  logic [1:0]         beat_cnt;

  logic [lines-1:0]   valid;
  logic [tag_w-1:0]   tags [lines];
  logic [63:0]        data_q [lines][4];

  logic [idx_w-1:0]   idx;
  logic [tag_w-1:0]   tag;
  logic [1:0]         beat;
  logic               hit;
  logic               is_write;
  ramio_pkg::lane_word_t cur_word;
  ramio_pkg::lane_word_t din_word;
  ramio_pkg::lane_word_t merged;

  // byte address split: tag | index | beat | word in beat | byte
  assign idx      = bus.address[5 +: idx_w];
  assign tag      = bus.address[5 + idx_w +: tag_w];
  assign beat     = bus.address[4:3];
  assign hit      = valid[idx] && tags[idx] == tag;
  assign is_write = bus.write_enable != 4'b0000;

  always_comb begin
    cur_word = bus.address[2] ? data_q[idx][beat][63:32] : data_q[idx][beat][31:0];
    din_word = bus.data_in;
    merged   = cur_word;
    // only the enabled byte lanes take the new data
    for (int i = 0; i < 4; i++) begin
      if (bus.write_enable[i]) merged.b[i] = din_word.b[i];
    end
  end

  assign bus.data_out       = cur_word;
  assign bus.data_out_ready = state == s_done;
  assign bus.busy           = (state == s_lookup && !hit) || state == s_fill ||
                              state == s_merge || state == s_write;

  // line address in double words, always 4-beat aligned
  assign br_addr    = {bus.address[5 +: `RAMIO_RAM_ADDR_W - 2], 2'b00};
  assign br_cmd     = state == s_write;
  // read request on a miss, write request with beat 0
  assign br_cmd_en  = (state == s_lookup && !hit) || (state == s_write && beat_cnt == 2'd0);
  assign br_wr_data = data_q[idx][beat_cnt];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= s_idle;
      beat_cnt <= '0;
      valid    <= '0;
    end else begin
      unique case (state)
        s_idle: if (bus.enable) state <= s_lookup;
        s_lookup: begin
          beat_cnt <= '0;
          if (!hit) state <= s_fill;
          else if (is_write) state <= s_merge;
          else state <= s_done;
        end
        // beats may arrive with gaps
        s_fill: if (br_rd_data_valid) begin
          beat_cnt <= beat_cnt + 2'd1;
          if (beat_cnt == 2'd3) begin
            valid[idx] <= 1'b1;
            state      <= is_write ? s_merge : s_done;
          end
        end
        s_merge: state <= s_write;
        s_write: begin
          beat_cnt <= beat_cnt + 2'd1;
          if (beat_cnt == 2'd3) state <= s_done;
        end
        s_done: state <= s_idle;
        default: state <= s_idle;
      endcase
    end
  end

  // line storage and tags
  always_ff @(posedge clk) begin
    if (state == s_fill && br_rd_data_valid) begin
      data_q[idx][beat_cnt] <= br_rd_data;
      if (beat_cnt == 2'd3) tags[idx] <= tag;
    end
    if (state == s_merge) begin
      if (bus.address[2]) data_q[idx][beat][63:32] <= merged;
      else data_q[idx][beat][31:0] <= merged;
    end
  end

endmodule

/* design/ramio.sv */
// ramio bridge
// decodes the LED and UART addresses, aligns all other accesses for the cache
// and sign or zero extends the read lane
`timescale 1ns/1ps
`include "ramio_config.svh"

module ramio (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    enable,
  // bit 2 signed, 01 byte, 10 half word, 11 word
  input  logic [2:0]              read_type,
  // 01 byte, 10 half word, 11 word
  input  logic [1:0]              write_type,
  input  logic [`RAMIO_ADDR_W-1:0] address,
  input  logic [`RAMIO_DATA_W-1:0] data_in,
  output logic [`RAMIO_DATA_W-1:0] data_out,
  output logic                    data_out_ready,
  output logic                    busy,
  output logic [3:0]              led,
  output logic                    uart_tx,
  input  logic                    uart_rx,
  cache_bus_if.client             bus
);

  logic                  is_led;
  logic                  is_uart_out;
  logic                  is_uart_in;
  logic                  is_io;
  ramio_pkg::lane_word_t wr_word;
  logic [3:0]            wr_en;
  ramio_pkg::lane_word_t rd_word;
  logic [7:0]            rd_byte;
  logic [15:0]           rd_half;
  // -1 when idle, else the sign extended byte in flight
  logic [15:0]           tx_reg;
  logic                  tx_go;
  logic                  tx_prev_go;
  logic                  tx_bsy;
  // -1 when empty
  logic [15:0]           rx_reg;
  logic                  rx_go;
  logic [7:0]            rx_data;
  logic                  rx_ready;

  assign is_led      = address == `RAMIO_ADDR_LED;
  assign is_uart_out = address == `RAMIO_ADDR_UART_OUT;
  assign is_uart_in  = address == `RAMIO_ADDR_UART_IN;
  assign is_io       = is_led || is_uart_out || is_uart_in;

  // I/O completes at once, everything else waits on the cache
  assign data_out_ready = enable && (is_io || bus.data_out_ready);
  assign busy           = is_io ? 1'b0 : bus.busy;

  // place write data into its lane, misaligned half words write nothing
  always_comb begin
    wr_word = '0;
    wr_en   = 4'b0000;
    unique case (write_type)
      2'b01: begin
        wr_word.b[address[1:0]] = data_in[7:0];
        wr_en = 4'b0001 << address[1:0];
      end
      2'b10: if (!address[0]) begin
        wr_word.h[address[1]] = data_in[15:0];
        wr_en = address[1] ? 4'b1100 : 4'b0011;
      end
      2'b11: begin
        wr_word = data_in;
        wr_en   = 4'b1111;
      end
      default: ;
    endcase
  end

  assign bus.enable       = enable && !is_io;
  assign bus.address      = {address[`RAMIO_ADDR_W-1:2], 2'b00};
  assign bus.data_in      = wr_word;
  assign bus.write_enable = wr_en;

  // pick and extend the read lane
  always_comb begin
    rd_word  = bus.data_out;
    rd_byte  = rd_word.b[address[1:0]];
    rd_half  = rd_word.h[address[1]];
    data_out = '0;
    if (is_uart_out) data_out = {{16{tx_reg[15]}}, tx_reg};
    else if (is_uart_in) data_out = {{16{rx_reg[15]}}, rx_reg};
    else if (is_led) data_out = {28'd0, led};
    else begin
      unique case (read_type[1:0])
        2'b01: data_out = {{24{read_type[2] & rd_byte[7]}}, rd_byte};
        // misaligned half word reads 0
        2'b10: if (!address[0]) data_out = {{16{read_type[2] & rd_half[15]}}, rd_half};
        2'b11: data_out = rd_word;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led        <= 4'b1111;
      tx_reg     <= 16'hFFFF;
      tx_go      <= 1'b0;
      tx_prev_go <= 1'b0;
      rx_reg     <= 16'hFFFF;
      rx_go      <= 1'b1;
    end else begin
      tx_prev_go <= 1'b0;
      // a read of UART in empties it, a byte waiting stays in the receiver
      if (enable && is_uart_in && read_type != 3'b000) rx_reg <= 16'hFFFF;
      else if (rx_go && rx_ready) begin
        rx_reg <= {{8{rx_data[7]}}, rx_data};
        rx_go  <= 1'b0;
      end
      // ack lasts one cycle
      if (!rx_go) rx_go <= 1'b1;
      // bsy is not up yet in the cycle right after go
      if (tx_go && !tx_bsy && !tx_prev_go) begin
        tx_go  <= 1'b0;
        tx_reg <= 16'hFFFF;
      end
      if (enable && is_uart_out && write_type != 2'b00) begin
        tx_reg     <= {{8{data_in[7]}}, data_in[7:0]};
        tx_go      <= 1'b1;
        tx_prev_go <= 1'b1;
      end
      if (enable && is_led && write_type != 2'b00) led <= data_in[3:0];
    end
  end

  uart_tx #(.clks_per_bit(`RAMIO_CLKS_PER_BIT)) u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .data  (tx_reg[7:0]),
    .go    (tx_go),
    .tx    (uart_tx),
    .bsy   (tx_bsy)
  );

  uart_rx #(.clks_per_bit(`RAMIO_CLKS_PER_BIT)) u_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (uart_rx),
    .go         (rx_go),
    .data       (rx_data),
    .data_ready (rx_ready)
  );

endmodule

/* design/ramio_top.sv */
// ramio top level
// bridge and cache joined by the cache bus, burst ram on plain ports
`timescale 1ns/1ps
`include "ramio_config.svh"

module ramio_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         enable,
  input  logic [2:0]                   read_type,
  input  logic [1:0]                   write_type,
  input  logic [`RAMIO_ADDR_W-1:0]     address,
  input  logic [`RAMIO_DATA_W-1:0]     data_in,
  output logic [`RAMIO_DATA_W-1:0]     data_out,
  output logic                         data_out_ready,
  output logic                         busy,
  output logic [3:0]                   led,
  output logic                         uart_tx,
  input  logic                         uart_rx,
  // burst ram, 64-bit beats
  output logic                         br_cmd,
  output logic                         br_cmd_en,
  output logic [`RAMIO_RAM_ADDR_W-1:0] br_addr,
  output logic [63:0]                  br_wr_data,
  input  logic [63:0]                  br_rd_data,
  input  logic                         br_rd_data_valid
);

  cache_bus_if #(.addr_w(`RAMIO_ADDR_W), .data_w(`RAMIO_DATA_W)) cbus ();

  ramio u_ramio (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable         (enable),
    .read_type      (read_type),
    .write_type     (write_type),
    .address        (address),
    .data_in        (data_in),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .busy           (busy),
    .led            (led),
    .uart_tx        (uart_tx),
    .uart_rx        (uart_rx),
    .bus            (cbus.client)
  );

  cache u_cache (
    .clk              (clk),
    .rst_n            (rst_n),
    .bus              (cbus.cache),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

endmodule

/* sim/ramio_chk.sv */
// ramio protocol checks
// concurrent assertions on the burst ram port and the client handshake
`timescale 1ns/1ps
`include "ramio_config.svh"

module ramio_chk (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         busy,
  input logic                         data_out_ready,
  input logic                         bus_enable,
  input logic                         bus_ready,
  input logic                         br_cmd_en,
  input logic [`RAMIO_RAM_ADDR_W-1:0] br_addr
);

  // assertion failures so far
  int fail_count = 0;

  // one command per pulse
  a_cmd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en |=> !br_cmd_en)
    else begin
      $error("br_cmd_en high for more than one cycle");
      fail_count++;
    end

  // bursts start on a line boundary
  a_line_addr: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en |-> br_addr[1:0] == 2'b00)
    else begin
      $error("br_addr not line aligned");
      fail_count++;
    end

  a_busy_ready: assert property (@(posedge clk) disable iff (!rst_n)
    !(busy && data_out_ready))
    else begin
      $error("busy and data_out_ready high together");
      fail_count++;
    end

  // the cache completes only a request that the bridge still holds
  a_ready_enable: assert property (@(posedge clk) disable iff (!rst_n)
    bus_ready |-> bus_enable)
    else begin
      $error("cache bus data_out_ready without enable");
      fail_count++;
    end

endmodule

bind ramio_top ramio_chk u_chk (
  .clk            (clk),
  .rst_n          (rst_n),
  .busy           (busy),
  .data_out_ready (data_out_ready),
  .bus_enable     (cbus.enable),
  .bus_ready      (cbus.data_out_ready),
  .br_cmd_en      (br_cmd_en),
  .br_addr        (br_addr)
);

/* sim/ramio_checker.sv */
// ramio result checker
// compares completed reads and the led value against expected values
// prints one line per row and the closing counts
`timescale 1ns/1ps

module ramio_checker (
  input  logic        clk,
  input  logic        enable,
  input  logic        data_out_ready,
  input  logic [31:0] data_out,
  input  logic [3:0]  led,
  // row context from the stimulus
  input  logic        chk_read,
  input  logic        skip_idle,
  input  logic        chk_led,
  input  logic [31:0] exp_val,
  input  logic        row_done,
  input  int          row_idx,
  input  logic        report,
  output int          err_count
);

  int   rows = 0;
  int   checks = 0;
  int   errs = 0;
  logic row_bad = 1'b0;

  assign err_count = errs;

  // outputs are settled at the falling edge
  always @(negedge clk) begin
    // polling reads of an empty UART in are not results
    if (enable && data_out_ready && chk_read &&
        !(skip_idle && data_out == 32'hFFFF_FFFF)) begin
      checks++;
      if (data_out !== exp_val) begin
        $display("[ERROR] %0t: row %0d data_out expected %h, got %h",
                 $time, row_idx, exp_val, data_out);
        errs++;
        row_bad = 1'b1;
      end
    end
    if (row_done) begin
      // led has taken the write by now
      if (chk_led) begin
        checks++;
        if (led !== exp_val[3:0]) begin
          $display("[ERROR] %0t: row %0d led expected %h, got %h",
                   $time, row_idx, exp_val[3:0], led);
          errs++;
          row_bad = 1'b1;
        end
      end
      if (row_bad) $display("row %0d: mismatch", row_idx);
      else $display("row %0d: ok", row_idx);
      rows++;
      row_bad = 1'b0;
    end
  end

  always @(posedge report) begin
    $display("rows %0d, checks %0d, errors %0d", rows, checks, errs);
  end

endmodule

/* sim/tb_top.sv */
// ramio testbench
// burst ram model, uart loopback, table driven accesses with a shadow byte model
`timescale 1ns/1ps
`include "ramio_config.svh"

module tb_top;

  localparam int K_WR   = 0;
  localparam int K_RD   = 1;
  // read with the expected value taken from the shadow bytes
  localparam int K_RDS  = 2;
  localparam int K_LED  = 3;
  localparam int K_POLL = 4;
  // idle for data_in cycles
  localparam int K_WAIT = 5;
  localparam int K_RND  = 6;
  localparam int MAX_ROWS  = 80;
  localparam int RAM_BYTES = 8 << `RAMIO_RAM_ADDR_W;
  localparam int POLL_MAX  = 200;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        enable;
  logic [2:0]  read_type;
  logic [1:0]  write_type;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic        busy;
  logic [3:0]  led;
  logic        uart_line;
  logic        br_cmd;
  logic        br_cmd_en;
  logic [`RAMIO_RAM_ADDR_W-1:0] br_addr;
  logic [63:0] br_wr_data;
  logic [63:0] br_rd_data = '0;
  logic        br_rd_data_valid = 1'b0;

  // row context for the checker
  logic        chk_read = 1'b0;
  logic        skip_idle = 1'b0;
  logic        chk_led = 1'b0;
  logic [31:0] exp_val = '0;
  logic        row_done = 1'b0;
  int          row_idx = 0;
  logic        report = 1'b0;
  int          err_count;
  logic        tb_fail = 1'b0;

  // stimulus table
  int          kinds [MAX_ROWS];
  logic [2:0]  rts [MAX_ROWS];
  logic [1:0]  wts [MAX_ROWS];
  logic [31:0] addrs [MAX_ROWS];
  logic [31:0] dins [MAX_ROWS];
  logic [31:0] exps [MAX_ROWS];
  int          nrows = 0;

  logic [7:0]  sh [RAM_BYTES];
  logic [63:0] ram [1 << `RAMIO_RAM_ADDR_W];
  int unsigned stim_rs = 37053;
  int          cycles = 0;
  int          limit = 0;

  always #50 clk = ~clk;

  ramio_top UUT (
    .clk              (clk),
    .rst_n            (rst_n),
    .enable           (enable),
    .read_type        (read_type),
    .write_type       (write_type),
    .address          (address),
    .data_in          (data_in),
    .data_out         (data_out),
    .data_out_ready   (data_out_ready),
    .busy             (busy),
    .led              (led),
    .uart_tx          (uart_line),
    .uart_rx          (uart_line),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

  ramio_checker u_checker (
    .clk            (clk),
    .enable         (enable),
    .data_out_ready (data_out_ready),
    .data_out       (data_out),
    .led            (led),
    .chk_read       (chk_read),
    .skip_idle      (skip_idle),
    .chk_led        (chk_led),
    .exp_val        (exp_val),
    .row_done       (row_done),
    .row_idx        (row_idx),
    .report         (report),
    .err_count      (err_count)
  );

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // initial memory contents, every address bit takes part
  function automatic logic [7:0] pattern_byte(input int a);
    return 8'(a) ^ 8'(a >> 8) ^ 8'h5A;
  endfunction

  // little endian byte model of what the RAM should hold
  function automatic logic [31:0] shadow_read(input logic [2:0] r, input logic [31:0] a);
    logic [12:0] x;
    logic [7:0]  b;
    logic [15:0] h;
    x = a[12:0];
    case (r[1:0])
      2'b01: begin
        b = sh[x];
        return r[2] ? {{24{b[7]}}, b} : {24'd0, b};
      end
      2'b10: begin
        // misaligned half words read 0
        if (x[0]) return 32'd0;
        h = {sh[x + 13'd1], sh[x]};
        return r[2] ? {{16{h[15]}}, h} : {16'd0, h};
      end
      2'b11: begin
        x[1:0] = 2'b00;
        return {sh[x + 13'd3], sh[x + 13'd2], sh[x + 13'd1], sh[x]};
      end
      default: return 32'd0;
    endcase
  endfunction

  task automatic shadow_write(input logic [1:0] w, input logic [31:0] a, input logic [31:0] d);
    logic [12:0] x;
    x = a[12:0];
    case (w)
      2'b01: sh[x] = d[7:0];
      2'b10: if (!x[0]) begin
        sh[x]         = d[7:0];
        sh[x + 13'd1] = d[15:8];
      end
      2'b11: begin
        x[1:0] = 2'b00;
        sh[x]         = d[7:0];
        sh[x + 13'd1] = d[15:8];
        sh[x + 13'd2] = d[23:16];
        sh[x + 13'd3] = d[31:24];
      end
      default: ;
    endcase
  endtask

  task automatic add_row(input int k, input logic [2:0] r, input logic [1:0] w,
                         input logic [31:0] a, input logic [31:0] d, input logic [31:0] e);
    kinds[nrows] = k;
    rts[nrows]   = r;
    wts[nrows]   = w;
    addrs[nrows] = a;
    dins[nrows]  = d;
    exps[nrows]  = e;
    nrows++;
  endtask

  // one access, held until data_out_ready, then enable drops
  task automatic do_access(input logic [2:0] r, input logic [1:0] w, input logic [31:0] a,
                           input logic [31:0] d, output logic [31:0] got);
    @(posedge clk);
    #1;
    enable     = 1'b1;
    read_type  = r;
    write_type = w;
    address    = a;
    data_in    = d;
    do @(negedge clk); while (!data_out_ready);
    got = data_out;
    @(posedge clk);
    #1;
    enable     = 1'b0;
    read_type  = 3'd0;
    write_type = 2'd0;
  endtask

  task automatic run_row(input int i);
    int          k;
    int          tries;
    int unsigned sel;
    logic [1:0]  code;
    logic [2:0]  r;
    logic [1:0]  w;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] got;
    k = kinds[i];
    r = rts[i];
    w = wts[i];
    a = addrs[i];
    d = dins[i];
    if (k == K_RND) begin
      stim_rs = lcg_next(stim_rs);
      sel     = stim_rs >> 16;
      code    = 2'(sel % 3 + 1);
      stim_rs = lcg_next(stim_rs);
      // half of the traffic stays in a small window so lines get reused
      a = sel[5] ? 32'((stim_rs >> 16) % 256) : 32'((stim_rs >> 16) % RAM_BYTES);
      if (code == 2'b10) a[0] = 1'b0;
      if (code == 2'b11) a[1:0] = 2'b00;
      stim_rs = lcg_next(stim_rs);
      d = stim_rs;
      if (sel[3]) begin
        k = K_WR;
        w = code;
        r = 3'd0;
      end else begin
        k = K_RDS;
        w = 2'd0;
        r = {sel[4] && code != 2'b11, code};
      end
    end
    row_idx   = i;
    chk_read  = k == K_RD || k == K_RDS || k == K_POLL;
    skip_idle = k == K_POLL;
    chk_led   = k == K_LED;
    exp_val   = k == K_RDS ? shadow_read(r, a) : exps[i];
    case (k)
      K_WAIT: begin
        repeat (d) @(posedge clk);
        #1;
      end
      K_POLL: begin
        tries = 0;
        got   = 32'hFFFF_FFFF;
        while (got == 32'hFFFF_FFFF && tries < POLL_MAX) begin
          do_access(r, w, a, d, got);
          tries++;
        end
        if (got == 32'hFFFF_FFFF) begin
          $display("row %0d: UART in stayed empty after %0d reads", i, tries);
          tb_fail = 1'b1;
        end
      end
      K_LED: if (w != 2'd0) do_access(r, w, a, d, got);
      default: begin
        do_access(r, w, a, d, got);
        if (k == K_WR && a < RAM_BYTES) shadow_write(w, a, d);
      end
    endcase
    row_done = 1'b1;
    @(posedge clk);
    #1;
    row_done = 1'b0;
  endtask

  // burst ram: reads answer after 3 to 6 cycles with gaps between beats
  initial begin : burst_ram
    int unsigned rs;
    logic [`RAMIO_RAM_ADDR_W-1:0] ba;
    rs = 37053;
    for (int i = 0; i < (1 << `RAMIO_RAM_ADDR_W); i++) begin
      for (int k = 0; k < 8; k++) ram[i][8*k +: 8] = pattern_byte(8 * i + k);
    end
    forever begin
      @(posedge clk);
      if (rst_n && br_cmd_en && br_cmd) begin
        // beat 0 comes with the command
        ba = br_addr;
        ram[ba] = br_wr_data;
        for (int b = 1; b < 4; b++) begin
          @(posedge clk);
          ram[ba + `RAMIO_RAM_ADDR_W'(b)] = br_wr_data;
        end
      end else if (rst_n && br_cmd_en) begin
        ba = br_addr;
        rs = lcg_next(rs);
        repeat (2 + (rs >> 16) % 4) @(posedge clk);
        for (int b = 0; b < 4; b++) begin
          #1;
          br_rd_data       = ram[ba + `RAMIO_RAM_ADDR_W'(b)];
          br_rd_data_valid = 1'b1;
          @(posedge clk);
          rs = lcg_next(rs);
          #1;
          br_rd_data_valid = 1'b0;
          if (rs[20]) @(posedge clk);
        end
      end
    end
  end

  // run limit from the table length
  always @(posedge clk) begin
    cycles++;
    if (limit != 0 && cycles >= limit) begin
      $display("run timed out after %0d cycles", cycles);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    rst_n      = 1'b0;
    enable     = 1'b0;
    read_type  = 3'd0;
    write_type = 2'd0;
    address    = '0;
    data_in    = '0;
    for (int a = 0; a < RAM_BYTES; a++) sh[a] = pattern_byte(a);

    // led after reset, then written
    add_row(K_LED, 3'd0, 2'd0, `RAMIO_ADDR_LED, 32'd0, 32'hF);
    add_row(K_LED, 3'd0, 2'd3, `RAMIO_ADDR_LED, 32'h5A, 32'hA);
    add_row(K_LED, 3'd0, 2'd1, `RAMIO_ADDR_LED, 32'h3, 32'h3);
    // word round trips: miss, hit, other index, eviction of index 0
    add_row(K_WR, 3'd0, 2'd3, 32'h100, 32'hDEAD_BEEF, 32'd0);
    add_row(K_RD, 3'd3, 2'd0, 32'h100, 32'd0, 32'hDEAD_BEEF);
    add_row(K_WR, 3'd0, 2'd3, 32'h124, 32'hCAFE_F00D, 32'd0);
    add_row(K_RD, 3'd3, 2'd0, 32'h124, 32'd0, 32'hCAFE_F00D);
    add_row(K_WR, 3'd0, 2'd3, 32'h140, 32'h1234_5678, 32'd0);
    add_row(K_RD, 3'd3, 2'd0, 32'h100, 32'd0, 32'hDEAD_BEEF);
    add_row(K_RD, 3'd3, 2'd0, 32'h140, 32'd0, 32'h1234_5678);
    // lanes and extension
    add_row(K_WR, 3'd0, 2'd1, 32'h101, 32'h80, 32'd0);
    add_row(K_WR, 3'd0, 2'd2, 32'h106, 32'hF00F, 32'd0);
    add_row(K_RDS, 3'd5, 2'd0, 32'h101, 32'd0, 32'd0);
    add_row(K_RDS, 3'd1, 2'd0, 32'h101, 32'd0, 32'd0);
    add_row(K_RDS, 3'd6, 2'd0, 32'h106, 32'd0, 32'd0);
    add_row(K_RDS, 3'd2, 2'd0, 32'h106, 32'd0, 32'd0);
    add_row(K_RDS, 3'd3, 2'd0, 32'h100, 32'd0, 32'd0);
    add_row(K_RDS, 3'd3, 2'd0, 32'h104, 32'd0, 32'd0);
    add_row(K_RD, 3'd2, 2'd0, 32'h103, 32'd0, 32'd0);
    add_row(K_WR, 3'd0, 2'd2, 32'h105, 32'hAAAA, 32'd0);
    add_row(K_RDS, 3'd3, 2'd0, 32'h104, 32'd0, 32'd0);
    // transmit register, then its byte arriving back at UART in
    add_row(K_WR, 3'd0, 2'd1, `RAMIO_ADDR_UART_OUT, 32'h3C, 32'd0);
    add_row(K_RD, 3'd3, 2'd0, `RAMIO_ADDR_UART_OUT, 32'd0, 32'h3C);
    add_row(K_WAIT, 3'd0, 2'd0, 32'd0, 32'(12 * `RAMIO_CLKS_PER_BIT), 32'd0);
    add_row(K_RD, 3'd3, 2'd0, `RAMIO_ADDR_UART_OUT, 32'd0, 32'hFFFF_FFFF);
    add_row(K_POLL, 3'd3, 2'd0, `RAMIO_ADDR_UART_IN, 32'd0, 32'h3C);
    add_row(K_RD, 3'd3, 2'd0, `RAMIO_ADDR_UART_IN, 32'd0, 32'hFFFF_FFFF);
    // negative byte through the loopback
    add_row(K_WR, 3'd0, 2'd1, `RAMIO_ADDR_UART_OUT, 32'hA5, 32'd0);
    add_row(K_RD, 3'd3, 2'd0, `RAMIO_ADDR_UART_OUT, 32'd0, 32'hFFFF_FFA5);
    add_row(K_POLL, 3'd3, 2'd0, `RAMIO_ADDR_UART_IN, 32'd0, 32'hFFFF_FFA5);
    add_row(K_RD, 3'd3, 2'd0, `RAMIO_ADDR_UART_IN, 32'd0, 32'hFFFF_FFFF);
    // random traffic
    for (int i = 0; i < 40; i++) add_row(K_RND, 3'd0, 2'd0, 32'd0, 32'd0, 32'd0);
    limit = nrows * (20 + 12 * `RAMIO_CLKS_PER_BIT);

    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < nrows; i++) run_row(i);

    report = 1'b1;
    #1;
    if (tb_fail || err_count != 0 || UUT.u_chk.fail_count != 0) begin
      $display("sim failed");
    end else begin
      $display("sim passed");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+design
design/ramio_pkg.sv
design/cache_bus_if.sv
design/uart_tx.sv
design/uart_rx.sv
design/cache.sv
design/ramio.sv
design/ramio_top.sv
sim/ramio_chk.sv
sim/ramio_checker.sv
sim/tb_top.sv

/* run.sh */
#!/bin/sh
# build and run the ramio testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_top -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if grep -q "^sim passed$" sim.log; then
  exit 0
fi
exit 1
